// File: Bender.yml
package:
  name: cfc

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cfc_pkg.sv
      - cfc_ckpt_ctrl.sv
      - cfc_rrat.sv
      - cfc_ckpt_table.sv
      - cfc.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clkgen.sv
      - cfc_asserts.sv
      - tb_cfc.sv

// File: cfc.sv
//******************************
// Copy-free checkpoint rename unit, top level
// Dispatch, ROB and CDB connect here
//******************************
`timescale 1ns/1ps
`default_nettype none

module cfc (
    input  wire                    clk,
    input  wire                    resetb,
    input  cfc_pkg::dispatch_req_t dispatch,
    input  cfc_pkg::commit_req_t   commit,
    input  cfc_pkg::rob_tag_t      rob_top,
    input  cfc_pkg::flush_req_t    flush,
    output cfc_pkg::rename_rsp_t   rename,
    output cfc_pkg::flush_rsp_t    flush_rsp,
    output logic                   full
);

    cfc_pkg::lookup_sel_t sel;          // Newest dirty slot per operand
    cfc_pkg::ckpt_idx_t   active_idx;   // Slot taking speculative writes
    cfc_pkg::rename_rsp_t rrat_rsp;     // Committed mappings, registered

    cfc_ckpt_ctrl u_ckpt_ctrl (
        .clk          (clk),
        .resetb       (resetb),
        .dispatch     (dispatch),
        .commit_valid (commit.valid),
        .rob_top      (rob_top),
        .flush        (flush),
        .sel          (sel),
        .active_idx   (active_idx),
        .flush_rsp    (flush_rsp),
        .full         (full)
    );

    cfc_rrat u_rrat (
        .clk      (clk),
        .resetb   (resetb),
        .dispatch (dispatch),
        .commit   (commit),
        .rsp      (rrat_rsp)
    );

    cfc_ckpt_table u_ckpt_table (
        .clk        (clk),
        .dispatch   (dispatch),
        .sel        (sel),
        .active_idx (active_idx),
        .rrat_rsp   (rrat_rsp),
        .rsp        (rename)
    );

endmodule

`default_nettype wire

// File: cfc_asserts.sv
//******************************
// Concurrent checks on the checkpoint ring control
// Bound into every cfc_ckpt_ctrl instance
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "cfc_params.svh"

module cfc_asserts (
    input wire                     clk,
    input wire                     resetb,
    input cfc_pkg::dispatch_req_t  dispatch,
    input cfc_pkg::flush_req_t     flush,
    input wire                     full,
    input wire [`CFC_CKPTS-1:0]    match,      // Valid slots holding the flushed tag
    input wire                     release_ok
);

    // A full ring only takes a branch when the tail frees up in the same cycle
    branch_into_full: assert property (@(posedge clk) disable iff (!resetb)
        (dispatch.valid && dispatch.branch && full) |-> release_ok)
        else $error("Branch dispatched into a full checkpoint ring");

    // Mispredicted branch must own exactly one live checkpoint
    flush_one_slot: assert property (@(posedge clk) disable iff (!resetb)
        flush.valid |-> $onehot(match))
        else $error("Flush tag does not select exactly one checkpoint");

    full_after_reset: assert property (@(posedge clk)
        $rose(resetb) |-> !full)
        else $error("Ring reports full right after reset");

endmodule

bind cfc_ckpt_ctrl cfc_asserts u_asserts (
    .clk        (clk),
    .resetb     (resetb),
    .dispatch   (dispatch),
    .flush      (flush),
    .full       (full),
    .match      (match),
    .release_ok (release_ok)
);

`default_nettype wire

// File: cfc_ckpt_ctrl.sv
//******************************
// Checkpoint ring control with pointers, tags, dirty flags,
// release and flush recovery, and the newest-slot search
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "cfc_params.svh"

module cfc_ckpt_ctrl (
    input  wire                    clk,
    input  wire                    resetb,
    input  cfc_pkg::dispatch_req_t dispatch,
    input  wire                    commit_valid,
    input  cfc_pkg::rob_tag_t      rob_top,
    input  cfc_pkg::flush_req_t    flush,
    output cfc_pkg::lookup_sel_t   sel,
    output cfc_pkg::ckpt_idx_t     active_idx,
    output cfc_pkg::flush_rsp_t    flush_rsp,
    output logic                   full
);

    cfc_pkg::ckpt_idx_t head;                        // Active map slot
    cfc_pkg::ckpt_idx_t tail;                        // Oldest checkpoint
    cfc_pkg::ckpt_idx_t span;                        // Live slots behind head
    logic [`CFC_CKPTS-1:0] slot_valid;               // Slot holds an unresolved branch
    cfc_pkg::rob_tag_t slot_tag [`CFC_CKPTS];        // Branch tag per slot
    cfc_pkg::frl_ptr_t slot_frl [`CFC_CKPTS];        // Saved free-list head
    logic [`CFC_LOG_REGS-1:0] dirty [`CFC_CKPTS];    // Registers written in each slot

    logic [`CFC_CKPTS-1:0] match;                    // Valid slot with the flushed tag
    cfc_pkg::rob_tag_t slot_depth [`CFC_CKPTS];      // Distance of each slot from ROB top
    cfc_pkg::rob_tag_t flush_depth;
    cfc_pkg::ckpt_idx_t flush_idx;
    logic flush_go;
    logic release_ok;
    logic create;
    logic dirty_set;
    logic [`CFC_CKPTS-1:0] rs_col;
    logic [`CFC_CKPTS-1:0] rt_col;
    logic [`CFC_CKPTS-1:0] rd_col;

    // Walk from head back towards tail and stop at the first dirty slot
    function automatic cfc_pkg::ckpt_sel_t find_newest(
        input logic [`CFC_CKPTS-1:0] col,
        input cfc_pkg::ckpt_idx_t    hd,
        input cfc_pkg::ckpt_idx_t    live
    );
        cfc_pkg::ckpt_sel_t res;
        cfc_pkg::ckpt_idx_t idx;
        res = '0;
        for (int k = 0; k < `CFC_CKPTS; k++) begin
            idx = hd - cfc_pkg::ckpt_idx_t'(k);
            if (!res.hit && (k <= int'(live)) && col[idx]) begin
                res.hit = 1'b1;
                res.idx = idx;
            end
        end
        return res;
    endfunction

    assign span        = head - tail;
    assign active_idx  = head;
    assign full        = (cfc_pkg::ckpt_idx_t'(head + 1'b1) == tail);
    assign flush_depth = flush.rob_tag - rob_top;
    assign flush_go    = flush.valid && (|match);

    // Oldest branch has reached the ROB top and commits
    assign release_ok = commit_valid && slot_valid[tail] && (slot_tag[tail] == rob_top);

    // Dispatch is ignored while a flush is on the CDB
    assign dirty_set = dispatch.valid && dispatch.reg_write && !flush.valid;
    assign create    = dispatch.valid && dispatch.branch && !flush.valid &&
                       (!full || release_ok);   // A full ring drops the branch

    always_comb begin
        flush_idx = head;                        // Holds when nothing matches
        for (int s = 0; s < `CFC_CKPTS; s++) begin
            match[s]      = slot_valid[s] && (slot_tag[s] == flush.rob_tag);
            slot_depth[s] = slot_tag[s] - rob_top;
            if (match[s])
                flush_idx = cfc_pkg::ckpt_idx_t'(s);
        end
    end

    assign flush_rsp.rob_tag  = slot_tag[flush_idx];
    assign flush_rsp.frl_head = slot_frl[flush_idx];

    // Per-operand dirty columns across the ring
    always_comb begin
        for (int s = 0; s < `CFC_CKPTS; s++) begin
            rs_col[s] = dirty[s][dispatch.rs];
            rt_col[s] = dirty[s][dispatch.rt];
            rd_col[s] = dirty[s][dispatch.rd];
        end
        sel.rs = find_newest(rs_col, head, span);
        sel.rt = find_newest(rt_col, head, span);
        sel.rd = find_newest(rd_col, head, span);
    end

    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            head       <= '0;
            tail       <= '0;
            slot_valid <= '0;
            for (int s = 0; s < `CFC_CKPTS; s++)
                dirty[s] <= '0;
        end else begin
            if (release_ok) begin
                slot_valid[tail] <= 1'b0;
                dirty[tail]      <= '0;                  // Its writes are now in the RRAT
                tail             <= tail + 1'b1;
            end
            if (flush_go) begin
                dirty[head] <= '0;                       // Active map after the branch is void
                for (int s = 0; s < `CFC_CKPTS; s++) begin
                    if (slot_depth[s] > flush_depth) begin   // Younger than the bad branch
                        slot_valid[s] <= 1'b0;
                        dirty[s]      <= '0;
                    end
                end
                slot_valid[flush_idx] <= 1'b0;           // Becomes the active map and keeps its flags
                head                  <= flush_idx;
            end else begin
                if (dirty_set)
                    dirty[head][dispatch.rd] <= 1'b1;
                if (create) begin
                    slot_valid[head] <= 1'b1;
                    head             <= head + 1'b1;
                end
            end
        end
    end

    // Branch tag and free-list head are written when the slot opens
    always_ff @(posedge clk) begin
        if (create) begin
            slot_tag[head] <= dispatch.branch_tag;
            slot_frl[head] <= dispatch.frl_head;
        end
    end

endmodule

`default_nettype wire

// File: cfc_ckpt_table.sv
//******************************
// Checkpoint map storage, one entry per slot and logical register
// Three registered read ports, merged with the retirement result
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "cfc_params.svh"

module cfc_ckpt_table (
    input  wire                    clk,
    input  cfc_pkg::dispatch_req_t dispatch,
    input  cfc_pkg::lookup_sel_t   sel,
    input  cfc_pkg::ckpt_idx_t     active_idx,
    input  cfc_pkg::rename_rsp_t   rrat_rsp,
    output cfc_pkg::rename_rsp_t   rsp
);

    localparam int DEPTH = `CFC_CKPTS * `CFC_LOG_REGS;

    cfc_pkg::phys_reg_t mem [DEPTH];            // Addressed {slot, logical reg}

    logic [`CFC_CKPT_W+`CFC_LOG_W-1:0] wr_addr;
    logic [`CFC_CKPT_W+`CFC_LOG_W-1:0] rs_addr;
    logic [`CFC_CKPT_W+`CFC_LOG_W-1:0] rt_addr;
    logic [`CFC_CKPT_W+`CFC_LOG_W-1:0] rd_addr;
    cfc_pkg::phys_reg_t rs_q;
    cfc_pkg::phys_reg_t rt_q;
    cfc_pkg::phys_reg_t rd_q;
    logic rs_hit_q;
    logic rt_hit_q;
    logic rd_hit_q;

    assign wr_addr = {active_idx, dispatch.rd};   // New mapping goes to the active map
    assign rs_addr = {sel.rs.idx, dispatch.rs};
    assign rt_addr = {sel.rt.idx, dispatch.rt};
    assign rd_addr = {sel.rd.idx, dispatch.rd};

    always_ff @(posedge clk) begin
        if (dispatch.valid) begin
            if (dispatch.reg_write)
                mem[wr_addr] <= dispatch.new_phys;
            rs_q     <= mem[rs_addr];     // Read before write, own write not seen
            rt_q     <= mem[rt_addr];
            rd_q     <= mem[rd_addr];
            rs_hit_q <= sel.rs.hit;
            rt_hit_q <= sel.rt.hit;
            rd_hit_q <= sel.rd.hit;
        end
    end

    // No dirty slot means the committed mapping is the newest one
    assign rsp.rs_phys      = rs_hit_q ? rs_q : rrat_rsp.rs_phys;
    assign rsp.rt_phys      = rt_hit_q ? rt_q : rrat_rsp.rt_phys;
    assign rsp.rd_prev_phys = rd_hit_q ? rd_q : rrat_rsp.rd_prev_phys;

endmodule

`default_nettype wire

// File: cfc_params.svh
//******************************
// Size macros for the checkpoint rename unit
// Included by the package and by every RTL file that sizes storage
//******************************
`ifndef CFC_PARAMS_SVH
`define CFC_PARAMS_SVH

// Logical register file
`define CFC_LOG_REGS 32            // Architectural registers
`define CFC_LOG_W    5             // Logical register number width

// Physical register file
`define CFC_PHYS_W   6             // 64 physical registers

// ROB and free list
`define CFC_ROB_W    5             // ROB tag width, 32 entries
`define CFC_FRL_W    5             // Free-list head pointer width

// Checkpoint ring
`define CFC_CKPTS    8             // Slots in the ring, one is always the active map
`define CFC_CKPT_W   3             // Slot index width

`endif

// File: cfc_pkg.sv
//******************************
// Field types and request/response structs of the checkpoint unit
// Shared by the RTL and the testbench through scoped names
//******************************
`default_nettype none

`include "cfc_params.svh"

package cfc_pkg;

    // Basic fields
    typedef logic [`CFC_LOG_W-1:0]  log_reg_t;   // Logical register number
    typedef logic [`CFC_PHYS_W-1:0] phys_reg_t;  // Physical register number
    typedef logic [`CFC_ROB_W-1:0]  rob_tag_t;   // ROB tag
    typedef logic [`CFC_FRL_W-1:0]  frl_ptr_t;   // Free-list pointer
    typedef logic [`CFC_CKPT_W-1:0] ckpt_idx_t;  // Checkpoint slot

    // One dispatched instruction
    typedef struct packed {
        logic      valid;       // Instruction present this cycle
        logic      reg_write;   // Writes rd
        logic      branch;      // Opens a checkpoint, jr 31 included
        log_reg_t  rd;
        log_reg_t  rs;
        log_reg_t  rt;
        phys_reg_t new_phys;    // Fresh physical register for rd
        rob_tag_t  branch_tag;  // ROB tag of the branch
        frl_ptr_t  frl_head;    // Free-list head when the branch dispatches
    } dispatch_req_t;

    // Retiring instruction from the ROB top
    typedef struct packed {
        logic      valid;
        logic      reg_write;
        log_reg_t  rd;
        phys_reg_t phys;        // Committed mapping of rd
    } commit_req_t;

    // Misprediction from the CDB
    typedef struct packed {
        logic     valid;
        rob_tag_t rob_tag;      // Tag of the mispredicted branch
    } flush_req_t;

    // Recovery point returned on a flush
    typedef struct packed {
        rob_tag_t rob_tag;      // ROB bottom moves here
        frl_ptr_t frl_head;     // Free list jumps back here
    } flush_rsp_t;

    // Newest-checkpoint search result for one operand
    typedef struct packed {
        logic      hit;         // Some live slot has the register dirty
        ckpt_idx_t idx;         // Newest such slot
    } ckpt_sel_t;

    typedef struct packed {
        ckpt_sel_t rs;
        ckpt_sel_t rt;
        ckpt_sel_t rd;
    } lookup_sel_t;

    // Rename lookup result
    typedef struct packed {
        phys_reg_t rs_phys;      // Newest mapping of rs
        phys_reg_t rt_phys;      // Newest mapping of rt
        phys_reg_t rd_prev_phys; // Mapping of rd before this write
    } rename_rsp_t;

endpackage

`default_nettype wire

// File: cfc_rrat.sv
//******************************
// Retirement map table, written by commits
// Gives the committed mappings of rs, rt and rd one cycle after dispatch
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "cfc_params.svh"

module cfc_rrat (
    input  wire                    clk,
    input  wire                    resetb,
    input  cfc_pkg::dispatch_req_t dispatch,
    input  cfc_pkg::commit_req_t   commit,
    output cfc_pkg::rename_rsp_t   rsp
);

    cfc_pkg::phys_reg_t map [`CFC_LOG_REGS];   // Committed logical to physical map

    // Commit writes, reset to identity
    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            for (int r = 0; r < `CFC_LOG_REGS; r++)
                map[r] <= cfc_pkg::phys_reg_t'(r);
        end else if (commit.valid && commit.reg_write) begin
            map[commit.rd] <= commit.phys;
        end
    end

    // Registered dispatch reads, old value on a same-cycle commit
    always_ff @(posedge clk) begin
        if (dispatch.valid) begin
            rsp.rs_phys      <= map[dispatch.rs];
            rsp.rt_phys      <= map[dispatch.rt];
            rsp.rd_prev_phys <= map[dispatch.rd];
        end
    end

endmodule

`default_nettype wire

// File: tb_cfc.sv
//******************************
// Testbench for the checkpoint rename unit
// Applies a table of dispatch, commit and flush rows and checks each response
//******************************
`timescale 1ns/1ps
`default_nettype none

module tb_cfc;

    // One table row, inputs first, then expected values
    typedef struct packed {
        cfc_pkg::dispatch_req_t d;
        cfc_pkg::commit_req_t   c;
        cfc_pkg::rob_tag_t      top;
        cfc_pkg::flush_req_t    f;
        cfc_pkg::rename_rsp_t   ren;    // Seen one cycle later
        cfc_pkg::flush_rsp_t    frsp;   // Same cycle
        logic                   full;   // Same cycle
        logic [2:0]             chk;    // {rename, flush response, full}
    } row_t;

    localparam logic [2:0] NONE = 3'b000;
    localparam logic [2:0] REN  = 3'b100;
    localparam logic [2:0] FRSP = 3'b010;
    localparam logic [2:0] FULL = 3'b001;

    logic                   clk;
    logic                   resetb;
    cfc_pkg::dispatch_req_t dispatch;
    cfc_pkg::commit_req_t   commit;
    cfc_pkg::rob_tag_t      rob_top;
    cfc_pkg::flush_req_t    flush;
    cfc_pkg::rename_rsp_t   rename;
    cfc_pkg::flush_rsp_t    flush_rsp;
    logic                   full;

    row_t rows [$];
    row_t row;
    int   waited;

    tb_clkgen u_clkgen (.clk(clk));

    cfc u_cfc (
        .clk       (clk),
        .resetb    (resetb),
        .dispatch  (dispatch),
        .commit    (commit),
        .rob_top   (rob_top),
        .flush     (flush),
        .rename    (rename),
        .flush_rsp (flush_rsp),
        .full      (full)
    );

    function automatic cfc_pkg::dispatch_req_t lookup_op(input int rs, input int rt, input int rd);
        cfc_pkg::dispatch_req_t d;
        d       = '0;
        d.valid = 1'b1;
        d.rs    = cfc_pkg::log_reg_t'(rs);
        d.rt    = cfc_pkg::log_reg_t'(rt);
        d.rd    = cfc_pkg::log_reg_t'(rd);
        return d;
    endfunction

    function automatic cfc_pkg::dispatch_req_t write_op(input int rs, input int rt, input int rd,
                                                        input int np);
        cfc_pkg::dispatch_req_t d;
        d           = lookup_op(rs, rt, rd);
        d.reg_write = 1'b1;
        d.new_phys  = cfc_pkg::phys_reg_t'(np);
        return d;
    endfunction

    function automatic cfc_pkg::dispatch_req_t branch_op(input int tag, input int frl);
        cfc_pkg::dispatch_req_t d;
        d            = '0;
        d.valid      = 1'b1;
        d.branch     = 1'b1;
        d.branch_tag = cfc_pkg::rob_tag_t'(tag);
        d.frl_head   = cfc_pkg::frl_ptr_t'(frl);
        return d;
    endfunction

    function automatic cfc_pkg::commit_req_t commit_op(input int wr, input int rd, input int phys);
        cfc_pkg::commit_req_t c;
        c.valid     = 1'b1;
        c.reg_write = (wr != 0);
        c.rd        = cfc_pkg::log_reg_t'(rd);
        c.phys      = cfc_pkg::phys_reg_t'(phys);
        return c;
    endfunction

    function automatic cfc_pkg::flush_req_t flush_op(input int tag);
        cfc_pkg::flush_req_t f;
        f.valid   = 1'b1;
        f.rob_tag = cfc_pkg::rob_tag_t'(tag);
        return f;
    endfunction

    function automatic cfc_pkg::rename_rsp_t mapping(input int rs, input int rt, input int rd);
        cfc_pkg::rename_rsp_t r;
        r.rs_phys      = cfc_pkg::phys_reg_t'(rs);
        r.rt_phys      = cfc_pkg::phys_reg_t'(rt);
        r.rd_prev_phys = cfc_pkg::phys_reg_t'(rd);
        return r;
    endfunction

    function automatic cfc_pkg::flush_rsp_t recovery(input int tag, input int frl);
        cfc_pkg::flush_rsp_t r;
        r.rob_tag  = cfc_pkg::rob_tag_t'(tag);
        r.frl_head = cfc_pkg::frl_ptr_t'(frl);
        return r;
    endfunction

    task automatic add_row(input cfc_pkg::dispatch_req_t d, input cfc_pkg::commit_req_t c,
                           input int top, input cfc_pkg::flush_req_t f,
                           input cfc_pkg::rename_rsp_t ren, input cfc_pkg::flush_rsp_t frsp,
                           input int full_exp, input logic [2:0] chk);
        row_t r;
        r.d    = d;
        r.c    = c;
        r.top  = cfc_pkg::rob_tag_t'(top);
        r.f    = f;
        r.ren  = ren;
        r.frsp = frsp;
        r.full = (full_exp != 0);
        r.chk  = chk;
        rows.push_back(r);
    endtask

    // Fields the unit ignores get random values
    function automatic row_t fill_unused(input row_t r);
        row_t o;
        o = r;
        if (!o.d.reg_write)
            o.d.new_phys = cfc_pkg::phys_reg_t'($urandom);
        if (!o.d.branch) begin
            o.d.branch_tag = cfc_pkg::rob_tag_t'($urandom);
            o.d.frl_head   = cfc_pkg::frl_ptr_t'($urandom);
        end
        if (!o.c.reg_write) begin
            o.c.rd   = cfc_pkg::log_reg_t'($urandom);
            o.c.phys = cfc_pkg::phys_reg_t'($urandom);
        end
        if (!o.f.valid)
            o.f.rob_tag = cfc_pkg::rob_tag_t'($urandom);
        return o;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "Stopping on first mismatch");
        end
    endtask

    task automatic build_table;
        // Identity map straight after reset
        add_row(lookup_op(3, 7, 12), '0, 0, '0, mapping(3, 7, 12), '0, 0, REN | FULL);
        add_row(lookup_op(31, 0, 20), '0, 0, '0, mapping(31, 0, 20), '0, 0, REN);
        // Slot 0 writes, lookups never see their own write
        add_row(write_op(5, 6, 5, 40), '0, 0, '0, mapping(5, 6, 5), '0, 0, REN);
        add_row(write_op(1, 2, 7, 45), '0, 0, '0, mapping(1, 2, 7), '0, 0, REN);
        add_row(lookup_op(5, 7, 5), '0, 0, '0, mapping(40, 45, 40), '0, 0, REN);
        add_row(branch_op(1, 10), '0, 0, '0, '0, '0, 0, FULL);
        // Slot 1, r5 rewritten so the newer slot must win
        add_row(write_op(5, 5, 5, 41), '0, 0, '0, mapping(40, 40, 40), '0, 0, REN);
        add_row(lookup_op(5, 8, 5), '0, 0, '0, mapping(41, 8, 41), '0, 0, REN);
        add_row(write_op(1, 2, 8, 42), '0, 0, '0, mapping(1, 2, 8), '0, 0, REN);
        add_row(branch_op(2, 14), '0, 0, '0, '0, '0, 0, FULL);
        // Slot 2 writes, discarded by the flush below
        add_row(write_op(0, 0, 5, 43), '0, 0, '0, mapping(0, 0, 41), '0, 0, REN);
        add_row(write_op(5, 8, 9, 44), '0, 0, '0, mapping(43, 42, 9), '0, 0, REN);
        add_row('0, '0, 0, flush_op(2), '0, recovery(2, 14), 0, FRSP | FULL);
        add_row(lookup_op(5, 9, 8), '0, 0, '0, mapping(41, 9, 42), '0, 0, REN);
        // Commit the slot 0 writes, then retire branch 1
        add_row('0, commit_op(1, 5, 40), 0, '0, '0, '0, 0, NONE);
        add_row('0, commit_op(1, 7, 45), 0, '0, '0, '0, 0, NONE);
        add_row(lookup_op(7, 5, 8), '0, 0, '0, mapping(45, 41, 42), '0, 0, REN);
        add_row('0, commit_op(0, 0, 0), 1, '0, '0, '0, 0, FULL);
        add_row(lookup_op(7, 5, 8), '0, 0, '0, mapping(45, 41, 42), '0, 0, REN);
        // Seven open branches fill the ring
        for (int t = 3; t <= 9; t++)
            add_row(branch_op(t, t + 16), '0, 0, '0, '0, '0, 0, FULL);
        add_row('0, '0, 0, '0, '0, '0, 1, FULL);
        add_row('0, commit_op(0, 0, 0), 3, '0, '0, '0, 1, FULL);  // Release shows next cycle
        add_row('0, '0, 0, '0, '0, '0, 0, FULL);
    endtask

    initial begin
        void'($urandom(82));
        resetb   = 1'b0;
        dispatch = '0;
        commit   = '0;
        rob_top  = '0;
        flush    = '0;
        build_table();
        repeat (8) @(negedge clk);
        resetb = 1'b1;
        waited = 0;
        while (!(resetb === 1'b1 && full === 1'b0)) begin
            if (waited == 16) begin
                $display("Timed out waiting for the unit to leave reset");
                $display("Test failed");
                $fatal(1, "Reset release timeout");
            end
            @(negedge clk);
            waited++;
        end
        for (int i = 0; i < rows.size(); i++) begin
            row      = fill_unused(rows[i]);
            dispatch = row.d;
            commit   = row.c;
            rob_top  = row.top;
            flush    = row.f;
            #1;                                 // Combinational outputs settle
            if (row.chk[1])
                check(32'(flush_rsp), 32'(row.frsp), $sformatf("row %0d flush_rsp", i));
            if (row.chk[0])
                check(32'(full), 32'(row.full), $sformatf("row %0d full", i));
            @(negedge clk);
            if (row.chk[2])
                check(32'(rename), 32'(row.ren), $sformatf("row %0d rename", i));
        end
        dispatch = '0;
        commit   = '0;
        flush    = '0;
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_clkgen.sv
//******************************
// Free-running testbench clock
// Starts low, rises half a period after time zero
//******************************
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter real PERIOD_NS = 4.0     // 250 MHz
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
cfc_pkg.sv
cfc_ckpt_ctrl.sv
cfc_rrat.sv
cfc_ckpt_table.sv
cfc.sv
tb_clkgen.sv
cfc_asserts.sv
tb_cfc.sv
